// ==== design/bus_types_pkg.sv ====
//////////////////////////////////////////////////
// memory write cycle phases
//////////////////////////////////////////////////
package bus_types_pkg;

    // three-cycle write, strobe sits in W1
    typedef enum logic [1:0] {
        PH_NONE = 2'd0,
        PH_W0   = 2'd1,
        PH_W1   = 2'd2,
        PH_W2   = 2'd3
    } wr_phase_e;

endpackage

// ==== design/cpu_types_pkg.sv ====
//////////////////////////////////////////////////
// opcode and index register select types
//////////////////////////////////////////////////
package cpu_types_pkg;

    // group 00101x0x, bit 2 picks the index register
    typedef enum logic [7:0] {
        OP_LD_NN_IX = 8'h28,
        OP_LD_NN_IY = 8'h2C
    } opcode_e;

    typedef enum logic {
        SEL_IX = 1'b0,
        SEL_IY = 1'b1
    } index_sel_e;

endpackage

// ==== design/decoder_2bit.sv ====
//////////////////////////////////////////////////
// enabled 2-bit decoder with half decodes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module decoder_2bit (
    input  logic       not_enable,
    input  logic [1:0] in_bits,
    input  logic [1:0] not_in_bits,
    output logic       out00,
    output logic       out01,
    output logic       out10,
    output logic       out11,
    output logic       out0x,
    output logic       out1x
);

    // nor of the disable and the bits that must be low
    assign out00 = ~(not_enable | in_bits[1] | in_bits[0]);
    assign out01 = ~(not_enable | in_bits[1] | not_in_bits[0]);
    assign out10 = ~(not_enable | not_in_bits[1] | in_bits[0]);
    assign out11 = ~(not_enable | not_in_bits[1] | not_in_bits[0]);

    // upper bit only
    assign out0x = ~(not_enable | in_bits[1]);
    assign out1x = ~(not_enable | not_in_bits[1]);

endmodule

// ==== design/decoder_ld_nn_index.sv ====
//////////////////////////////////////////////////
// LD (nn),IX/IY step decode into control strobes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "decoder_macros.svh"

module decoder_ld_nn_index (
    input  logic                 enable,
    input  logic [`XPT_W-1:0]    xpt,
    input  logic [`XPT_W-1:0]    not_xpt,
    input  logic [`ITABLE_W-1:0] itable,
    input  logic [`ITABLE_W-1:0] not_itable,
    output logic [`XPT_LAST:0]   decoded_xpt,
    output logic                 set_ild_ix,
    output logic                 set_ild_iy,
    output logic                 set_cmr,
    output logic                 reset_xpt,
    output logic                 sel_ix_low,
    output logic                 sel_iy_low,
    output logic                 sel_ix_high,
    output logic                 sel_iy_high,
    output logic                 sel_addr_plus1,
    output logic                 sel_addr_operand,
    output logic                 pc_w0,
    output logic                 pc_w1,
    output logic                 pc_w2,
    output logic                 set_cm1,
    output logic                 reset_itable,
    output logic                 op_head
);

    // opcode bit that tells IY from IX
    localparam logic [7:0] op_ix   = cpu_types_pkg::OP_LD_NN_IX;
    localparam logic [7:0] op_iy   = cpu_types_pkg::OP_LD_NN_IY;
    localparam int         sel_bit = $clog2(op_ix ^ op_iy);

    logic not_enable, setup, step, not_step;
    logic t00xx, t01xx, t0xxx, t1xxx, not_t0xxx;
    logic l00, l01, l10, l11, l0x, l1x;
    logic t4or5, t6or7, low_rng, high_rng;

    assign not_enable = ~enable;

    // phase bit 0 of itable, inline 1-bit decode
    assign setup    = ~(not_enable | itable[0]);
    assign step     = ~(not_enable | not_itable[0]);
    assign not_step = ~step;

    assign set_ild_ix = ~(~setup | itable[sel_bit]);
    assign set_ild_iy = ~(~setup | not_itable[sel_bit]);
    assign set_cmr    = setup;

    decoder_2bit u_xpt_hi (
        .not_enable  (not_step),
        .in_bits     (xpt[3:2]),
        .not_in_bits (not_xpt[3:2]),
        .out00       (t00xx),
        .out01       (t01xx),
        .out10       (),
        .out11       (),
        .out0x       (t0xxx),
        .out1x       (t1xxx)
    );

    assign not_t0xxx = ~t0xxx;

    decoder_2bit u_xpt_lo (
        .not_enable  (not_t0xxx),
        .in_bits     (xpt[1:0]),
        .not_in_bits (not_xpt[1:0]),
        .out00       (l00),
        .out01       (l01),
        .out10       (l10),
        .out11       (l11),
        .out0x       (l0x),
        .out1x       (l1x)
    );

    assign decoded_xpt[0] = t00xx & l00;
    assign decoded_xpt[1] = t00xx & l01;
    assign decoded_xpt[2] = t00xx & l10;
    assign decoded_xpt[3] = t00xx & l11;
    assign decoded_xpt[4] = t01xx & l00;
    assign decoded_xpt[5] = t01xx & l01;
    assign decoded_xpt[6] = t01xx & l10;
    assign decoded_xpt[7] = t01xx & l11;
    // xpt stops at 8, so 1xxx is enough
    assign decoded_xpt[8] = t1xxx;

    assign t4or5    = t01xx & l0x;
    assign t6or7    = t01xx & l1x;
    assign low_rng  = decoded_xpt[3] | t4or5;
    assign high_rng = t6or7 | decoded_xpt[8];

    // low byte at nn, high byte at nn+1
    assign sel_ix_low       = low_rng & not_itable[sel_bit];
    assign sel_iy_low       = low_rng & itable[sel_bit];
    assign sel_ix_high      = high_rng & not_itable[sel_bit];
    assign sel_iy_high      = high_rng & itable[sel_bit];
    assign sel_addr_plus1   = high_rng;
    assign sel_addr_operand = low_rng | high_rng;

    assign pc_w0 = decoded_xpt[3] | decoded_xpt[6];
    assign pc_w1 = decoded_xpt[4] | decoded_xpt[7];
    assign pc_w2 = decoded_xpt[5] | decoded_xpt[8];

    // step 8 ends the instruction
    assign reset_xpt    = setup | decoded_xpt[8];
    assign set_cm1      = decoded_xpt[8];
    assign reset_itable = decoded_xpt[8];
    assign op_head      = decoded_xpt[8];

    always_comb begin
        assert ($onehot0({sel_ix_low, sel_iy_low, sel_ix_high, sel_iy_high}))
            else $error("index byte selects overlap");
        assert ($onehot0({pc_w0, pc_w1, pc_w2}))
            else $error("write phase strobes overlap");
    end

endmodule

// ==== design/index_datapath.sv ====
//////////////////////////////////////////////////
// IX/IY registers and memory write address/data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "decoder_macros.svh"

module index_datapath (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      index_load,
    input  cpu_types_pkg::index_sel_e index_target,
    input  logic [`ADDR_W-1:0]        index_value,
    input  logic [`ADDR_W-1:0]        operand,
    input  logic                      latch_operand,
    input  logic                      set_ild_ix,
    input  logic                      set_ild_iy,
    input  logic                      sel_ix_low,
    input  logic                      sel_iy_low,
    input  logic                      sel_ix_high,
    input  logic                      sel_iy_high,
    input  logic                      sel_addr_plus1,
    input  logic                      sel_addr_operand,
    input  logic                      pc_w0,
    input  logic                      pc_w1,
    input  logic                      pc_w2,
    output logic [`ADDR_W-1:0]        mem_addr,
    output logic [`DATA_W-1:0]        mem_data,
    output logic                      mem_wr
);

    logic [`ADDR_W-1:0]        ix, iy, nn, nn_plus1, index_word;
    logic                      sel_low, sel_high;
    cpu_types_pkg::index_sel_e index_sel;
    bus_types_pkg::wr_phase_e  wr_phase;

    always_ff @(posedge clk) begin
        if (index_load && index_target == cpu_types_pkg::SEL_IX) begin
            ix <= index_value;
        end
        if (index_load && index_target == cpu_types_pkg::SEL_IY) begin
            iy <= index_value;
        end
        if (latch_operand) begin
            nn <= operand;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index_sel <= cpu_types_pkg::SEL_IX;
        end else if (set_ild_iy) begin
            index_sel <= cpu_types_pkg::SEL_IY;
        end else if (set_ild_ix) begin
            index_sel <= cpu_types_pkg::SEL_IX;
        end
    end

    // wraps at ffff
    assign nn_plus1 = nn + `ADDR_W'(1);
    assign mem_addr = sel_addr_operand ? (sel_addr_plus1 ? nn_plus1 : nn) : '0;

    assign index_word = (index_sel == cpu_types_pkg::SEL_IY) ? iy : ix;
    assign sel_low    = sel_ix_low | sel_iy_low;
    assign sel_high   = sel_ix_high | sel_iy_high;
    assign mem_data   = ({`DATA_W{sel_low}} & index_word[7:0])
                      | ({`DATA_W{sel_high}} & index_word[15:8]);

    assign mem_wr = pc_w1;

    always_comb begin
        if (pc_w2) begin
            wr_phase = bus_types_pkg::PH_W2;
        end else if (pc_w1) begin
            wr_phase = bus_types_pkg::PH_W1;
        end else if (pc_w0) begin
            wr_phase = bus_types_pkg::PH_W0;
        end else begin
            wr_phase = bus_types_pkg::PH_NONE;
        end
    end

    a_wr_has_byte: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr |-> (sel_low || sel_high));

    // W0, W1, W2 in order
    a_phase_order: assert property (@(posedge clk) disable iff (!arst_n)
        wr_phase == bus_types_pkg::PH_W1 || wr_phase == bus_types_pkg::PH_W2
        |-> $past(wr_phase) == wr_phase - 2'd1);

    a_sel_matches: assert property (@(posedge clk) disable iff (!arst_n)
        (sel_iy_low || sel_iy_high) |-> index_sel == cpu_types_pkg::SEL_IY);

endmodule

// ==== design/index_store_top.sv ====
//////////////////////////////////////////////////
// LD (nn),IX/IY execution slice
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "decoder_macros.svh"

module index_store_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      opcode_valid,
    input  logic [`ITABLE_W-1:0]      opcode,
    input  logic [`ADDR_W-1:0]        operand,
    input  logic                      index_load,
    input  cpu_types_pkg::index_sel_e index_target,
    input  logic [`ADDR_W-1:0]        index_value,
    output logic [`ADDR_W-1:0]        mem_addr,
    output logic [`DATA_W-1:0]        mem_data,
    output logic                      mem_wr,
    output logic                      busy,
    output logic                      done
);

    logic [`XPT_W-1:0]    xpt, not_xpt;
    logic [`ITABLE_W-1:0] itable, not_itable;
    logic set_ild_ix, set_ild_iy, set_cmr, set_phase, reset_xpt, reset_itable;
    logic sel_ix_low, sel_iy_low, sel_ix_high, sel_iy_high;
    logic sel_addr_plus1, sel_addr_operand, pc_w0, pc_w1, pc_w2;

    assign set_phase = set_ild_ix | set_ild_iy;

    step_sequencer u_seq (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_valid (opcode_valid),
        .opcode       (opcode),
        .reset_xpt    (reset_xpt),
        .set_phase    (set_phase),
        .reset_itable (reset_itable),
        .xpt          (xpt),
        .not_xpt      (not_xpt),
        .itable       (itable),
        .not_itable   (not_itable),
        .busy         (busy)
    );

    decoder_ld_nn_index u_dec (
        .enable           (busy),
        .xpt              (xpt),
        .not_xpt          (not_xpt),
        .itable           (itable),
        .not_itable       (not_itable),
        .decoded_xpt      (),
        .set_ild_ix       (set_ild_ix),
        .set_ild_iy       (set_ild_iy),
        .set_cmr          (set_cmr),
        .reset_xpt        (reset_xpt),
        .sel_ix_low       (sel_ix_low),
        .sel_iy_low       (sel_iy_low),
        .sel_ix_high      (sel_ix_high),
        .sel_iy_high      (sel_iy_high),
        .sel_addr_plus1   (sel_addr_plus1),
        .sel_addr_operand (sel_addr_operand),
        .pc_w0            (pc_w0),
        .pc_w1            (pc_w1),
        .pc_w2            (pc_w2),
        .set_cm1          (),
        .reset_itable     (reset_itable),
        .op_head          (done)
    );

    index_datapath u_dp (
        .clk              (clk),
        .arst_n           (arst_n),
        .index_load       (index_load),
        .index_target     (index_target),
        .index_value      (index_value),
        .operand          (operand),
        .latch_operand    (set_cmr),
        .set_ild_ix       (set_ild_ix),
        .set_ild_iy       (set_ild_iy),
        .sel_ix_low       (sel_ix_low),
        .sel_iy_low       (sel_iy_low),
        .sel_ix_high      (sel_ix_high),
        .sel_iy_high      (sel_iy_high),
        .sel_addr_plus1   (sel_addr_plus1),
        .sel_addr_operand (sel_addr_operand),
        .pc_w0            (pc_w0),
        .pc_w1            (pc_w1),
        .pc_w2            (pc_w2),
        .mem_addr         (mem_addr),
        .mem_data         (mem_data),
        .mem_wr           (mem_wr)
    );

endmodule

// ==== design/step_sequencer.sv ====
//////////////////////////////////////////////////
// itable latch, phase flag and xpt step counter
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "decoder_macros.svh"

module step_sequencer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 opcode_valid,
    input  logic [`ITABLE_W-1:0] opcode,
    input  logic                 reset_xpt,
    input  logic                 set_phase,
    input  logic                 reset_itable,
    output logic [`XPT_W-1:0]    xpt,
    output logic [`XPT_W-1:0]    not_xpt,
    output logic [`ITABLE_W-1:0] itable,
    output logic [`ITABLE_W-1:0] not_itable,
    output logic                 busy
);

    localparam logic [7:0] op_group = cpu_types_pkg::OP_LD_NN_IX;

    logic accept;

    // 00101x0x only, and only when idle
    assign accept = opcode_valid && !busy
                    && (opcode[7:3] == op_group[7:3]) && !opcode[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            itable <= '0;
            busy   <= 1'b0;
        end else if (reset_itable) begin
            itable <= '0;
            busy   <= 1'b0;
        end else if (accept) begin
            // phase bit starts cleared for the setup cycle
            itable <= {opcode[7:1], 1'b0};
            busy   <= 1'b1;
        end else if (set_phase) begin
            itable[0] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xpt <= '0;
        end else if (reset_xpt) begin
            xpt <= '0;
        end else if (busy) begin
            xpt <= xpt + `XPT_W'(1);
        end
    end

    assign not_xpt    = ~xpt;
    assign not_itable = ~itable;

    a_xpt_limit: assert property (@(posedge clk) disable iff (!arst_n)
        xpt <= `XPT_W'(`XPT_LAST));

    a_itable_hold: assert property (@(posedge clk) disable iff (!arst_n)
        busy && $past(busy) |-> itable[7:1] == $past(itable[7:1]));

endmodule

// ==== files.f ====
+incdir+include
design/cpu_types_pkg.sv
design/bus_types_pkg.sv
design/decoder_2bit.sv
design/decoder_ld_nn_index.sv
design/step_sequencer.sv
design/index_datapath.sv
design/index_store_top.sv
sim/tb_index_store.sv

// ==== include/decoder_macros.svh ====
//////////////////////////////////////////////////
// widths and step limits for the index store slice
//////////////////////////////////////////////////
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

// bus and register widths
`define XPT_W     4
`define ITABLE_W  8
`define ADDR_W    16
`define DATA_W    8

// last step of LD (nn),IX/IY
`define XPT_LAST  8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the index store testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_index_store -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== sim/tb_index_store.sv ====
//////////////////////////////////////////////////
// testbench for the LD (nn),IX/IY execution slice
// timing model, concurrent checks and watchdog
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "decoder_macros.svh"

module tb_index_store;

    localparam time period     = 100ns;
    localparam int  wr_age_low  = 5;
    localparam int  wr_age_high = 8;
    localparam int  done_age    = 9;
    // reset, idle, four stores, rejects
    localparam int  total_cycles = 6 + 8 + 4 * 24 + 32;

    logic                      clk, arst_n, opcode_valid, index_load;
    logic [`ITABLE_W-1:0]      opcode;
    logic [`ADDR_W-1:0]        operand, index_value, mem_addr;
    logic [`DATA_W-1:0]        mem_data;
    logic                      mem_wr, busy, done;
    cpu_types_pkg::index_sel_e index_target;

    logic [15:0]        lfsr;
    logic [`ADDR_W-1:0] ix_m, iy_m, nn_m, word_m, exp_addr;
    logic [`DATA_W-1:0] exp_data;
    logic               active, sel_iy_m, exp_busy, exp_wr, exp_done;
    int                 age, wr_count, done_count;
    int                 err_count, pass_count, fail_count;

    index_store_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_valid (opcode_valid),
        .opcode       (opcode),
        .operand      (operand),
        .index_load   (index_load),
        .index_target (index_target),
        .index_value  (index_value),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_wr       (mem_wr),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic in_group(input logic [7:0] op);
        return (op[7:3] == 5'b00101) && !op[1];
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // reference timing, age counts edges since accept
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            age        <= 0;
            sel_iy_m   <= 1'b0;
            wr_count   <= 0;
            done_count <= 0;
        end else begin
            if (index_load) begin
                if (index_target == cpu_types_pkg::SEL_IX) begin
                    ix_m <= index_value;
                end else begin
                    iy_m <= index_value;
                end
            end
            if (mem_wr) begin
                wr_count <= wr_count + 1;
            end
            if (done) begin
                done_count <= done_count + 1;
            end
            if (!active) begin
                if (opcode_valid && in_group(opcode)) begin
                    active   <= 1'b1;
                    age      <= 0;
                    sel_iy_m <= opcode[2];
                end
            end else begin
                if (age == 0) begin
                    nn_m <= operand;
                end
                if (age == done_age) begin
                    active <= 1'b0;
                end else begin
                    age <= age + 1;
                end
            end
        end
    end

    assign exp_busy = active;
    assign exp_wr   = active && (age == wr_age_low || age == wr_age_high);
    assign exp_done = active && (age == done_age);
    assign word_m   = sel_iy_m ? iy_m : ix_m;
    assign exp_addr = (age == wr_age_high) ? nn_m + 16'd1 : nn_m;
    assign exp_data = (age == wr_age_high) ? word_m[15:8] : word_m[7:0];

    task automatic flag_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        err_count++;
        $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    a_busy: assert property (@(posedge clk) disable iff (!arst_n) busy == exp_busy)
        else flag_mismatch("busy", 16'($sampled(busy)), 16'($sampled(exp_busy)));
    a_wr: assert property (@(posedge clk) disable iff (!arst_n) mem_wr == exp_wr)
        else flag_mismatch("mem_wr", 16'($sampled(mem_wr)), 16'($sampled(exp_wr)));
    a_done: assert property (@(posedge clk) disable iff (!arst_n) done == exp_done)
        else flag_mismatch("done", 16'($sampled(done)), 16'($sampled(exp_done)));
    a_addr: assert property (@(posedge clk) disable iff (!arst_n)
        exp_wr |-> mem_addr == exp_addr)
        else flag_mismatch("mem_addr", $sampled(mem_addr), $sampled(exp_addr));
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        exp_wr |-> mem_data == exp_data)
        else flag_mismatch("mem_data", 16'($sampled(mem_data)), 16'($sampled(exp_data)));

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic load_index(input cpu_types_pkg::index_sel_e target,
                              input logic [15:0] value);
        tick();
        index_load   = 1'b1;
        index_target = target;
        index_value  = value;
        tick();
        index_load = 1'b0;
    endtask

    // operand stays put until the next opcode
    task automatic issue_opcode(input logic [7:0] op, input logic [15:0] nn);
        tick();
        opcode_valid = 1'b1;
        opcode       = op;
        operand      = nn;
        tick();
        opcode_valid = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            err_count++;
            $display("no done pulse within %0d cycles of the opcode", limit);
        end
        repeat (3) tick();
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_count++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic close_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %0d %s: ok", num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", num, name,
                     err_count - errs_before);
        end
    endtask

    task automatic run_store(input int num, input string name,
                             input cpu_types_pkg::index_sel_e target,
                             input logic [7:0] op, input logic [15:0] nn);
        logic [15:0] value;
        int errs, wr0, done0;
        errs  = err_count;
        take_bits(16, value);
        load_index(target, value);
        wr0   = wr_count;
        done0 = done_count;
        issue_opcode(op, nn);
        wait_done(16);
        check_count("write count", wr_count - wr0, 2);
        check_count("done count", done_count - done0, 1);
        close_test(num, name, errs);
    endtask

    initial begin
        #(total_cycles * period * 3 / 2);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [15:0] v, nn;
        int errs, wr0, done0;
        arst_n       = 1'b0;
        opcode_valid = 1'b0;
        opcode       = '0;
        operand      = '0;
        index_load   = 1'b0;
        index_target = cpu_types_pkg::SEL_IX;
        index_value  = '0;
        lfsr         = 16'd75;
        err_count    = 0;
        pass_count   = 0;
        fail_count   = 0;
        repeat (5) @(posedge clk);
        #5;
        arst_n = 1'b1;

        errs = err_count;
        repeat (6) tick();
        check_count("write count", wr_count, 0);
        close_test(1, "idle after reset", errs);

        take_bits(16, nn);
        run_store(2, "store IX", cpu_types_pkg::SEL_IX, cpu_types_pkg::OP_LD_NN_IX, nn);
        take_bits(16, nn);
        run_store(3, "store IY", cpu_types_pkg::SEL_IY, cpu_types_pkg::OP_LD_NN_IY, nn);
        run_store(4, "address wrap", cpu_types_pkg::SEL_IX, cpu_types_pkg::OP_LD_NN_IX,
                  16'hFFFF);

        // second opcode and an IX reload land while busy
        errs  = err_count;
        wr0   = wr_count;
        done0 = done_count;
        take_bits(16, nn);
        issue_opcode(cpu_types_pkg::OP_LD_NN_IX, nn);
        tick();
        opcode_valid = 1'b1;
        opcode       = cpu_types_pkg::OP_LD_NN_IY;
        tick();
        opcode_valid = 1'b0;
        take_bits(16, v);
        load_index(cpu_types_pkg::SEL_IX, v);
        wait_done(16);
        check_count("write count", wr_count - wr0, 2);
        check_count("done count", done_count - done0, 1);
        close_test(5, "opcode while busy", errs);

        errs = err_count;
        wr0  = wr_count;
        issue_opcode(8'h2A, nn);
        repeat (12) tick();
        v = 16'h0028;
        while (in_group(v[7:0])) begin
            take_bits(8, v);
        end
        issue_opcode(v[7:0], nn);
        repeat (12) tick();
        check_count("write count", wr_count - wr0, 0);
        close_test(6, "rejected opcodes", errs);

        $display("tests: %0d passed, %0d failed, %0d errors",
                 pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
